//--- verilog/fwrisc_csr_pkg.sv
`default_nettype none

package fwrisc_csr_pkg;

	// datapath width and register-file index width
	localparam int xlen = 32;
	localparam int reg_idx_w = 6; // bit 5 set selects CSR space

	// the low 5 bits of the CSR address are kept
	localparam int csr_keep_w = reg_idx_w - 1;

	// base opcode shared by all CSR instructions
	localparam logic [6:0] opcode_system = 7'b1110011;

	// funct3 bits 1:0 select the CSR operation, bit 2 the immediate form
	localparam logic [1:0] funct3_rw = 2'b01;
	localparam logic [1:0] funct3_rs = 2'b10;
	localparam logic [1:0] funct3_rc = 2'b11;

	// operation class handed from decoder to execute
	typedef enum logic {
		OP_TYPE_CSR = 1'b0,
		OP_TYPE_ILLEGAL = 1'b1
	} op_type_t;

	// how the new CSR value is formed from the old one and operand A
	typedef enum logic [1:0] {
		OP_OPA = 2'b00, // new value is operand A
		OP_OR = 2'b01, // old value OR operand A
		OP_CLR = 2'b10 // old value AND NOT operand A
	} alu_op_t;

endpackage

`default_nettype wire

//--- verilog/fwrisc_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decoded operation from the decoder to the execute block
interface fwrisc_decode_if;
	import fwrisc_csr_pkg::*;

	logic decode_valid; // stays high until instr_complete
	op_type_t op_type;
	alu_op_t op;
	logic [4:0] rs1;
	logic [4:0] zimm;
	logic use_zimm; // operand A comes from zimm rather than rs1
	logic [reg_idx_w-1:0] rd;
	logic [reg_idx_w-1:0] csr;
	logic instr_complete; // single-cycle pulse from the execute block

	modport decode (
		output decode_valid, op_type, op, rs1, zimm, use_zimm, rd, csr,
		input instr_complete
	);

	modport exec (
		input decode_valid, op_type, op, rs1, zimm, use_zimm, rd, csr,
		output instr_complete
	);
endinterface

// read and write ports between the execute block and the register file
interface fwrisc_rf_if;
	import fwrisc_csr_pkg::*;

	logic [reg_idx_w-1:0] rs1_addr;
	logic [reg_idx_w-1:0] csr_addr;
	logic [xlen-1:0] rs1_data; // combinational read data
	logic [xlen-1:0] csr_data;
	logic gpr_we;
	logic [reg_idx_w-1:0] gpr_waddr;
	logic [xlen-1:0] gpr_wdata;
	logic csr_we;
	logic [reg_idx_w-1:0] csr_waddr;
	logic [xlen-1:0] csr_wdata;

	modport exec (
		output rs1_addr, csr_addr, gpr_we, gpr_waddr, gpr_wdata,
		output csr_we, csr_waddr, csr_wdata,
		input rs1_data, csr_data
	);

	modport rf (
		input rs1_addr, csr_addr, gpr_we, gpr_waddr, gpr_wdata,
		input csr_we, csr_waddr, csr_wdata,
		output rs1_data, csr_data
	);
endinterface

`default_nettype wire

//--- verilog/fwrisc_csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fwrisc_csr_decode (
	input logic clock,
	input logic reset,
	input logic instr_valid,
	input logic [fwrisc_csr_pkg::xlen-1:0] instr,
	fwrisc_decode_if.decode dec
);
	import fwrisc_csr_pkg::*;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_t;

	state_t state;
	logic accept;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic is_system;
	logic legal;
	alu_op_t op_w;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign is_system = (opcode == opcode_system);

	// a strobe is taken only when nothing is in flight
	assign accept = instr_valid && (state == ST_IDLE);

	// valid drops in the same cycle the execute block reports completion
	assign dec.decode_valid = (state == ST_BUSY) && !dec.instr_complete;

	// funct3 of 000 and 100 are not CSR accesses
	always_comb begin
		legal = is_system;
		case (funct3[1:0])
			funct3_rw: op_w = OP_OPA;
			funct3_rs: op_w = OP_OR;
			funct3_rc: op_w = OP_CLR;
			default: begin
				op_w = OP_OPA;
				legal = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (instr_valid) begin
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (dec.instr_complete) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// decoded fields are held until the next accepted strobe
	always_ff @(posedge clock) begin
		if (accept) begin
			dec.op_type <= legal ? OP_TYPE_CSR : OP_TYPE_ILLEGAL;
			dec.op <= op_w;
			dec.rs1 <= instr[19:15];
			dec.zimm <= instr[19:15]; // the immediate sits in the rs1 field
			dec.use_zimm <= funct3[2];
			dec.rd <= {1'b0, instr[11:7]};
			// only the low bits of the 12-bit CSR address select an entry
			dec.csr <= {1'b1, instr[20 +: csr_keep_w]};
		end
	end

endmodule

`default_nettype wire

//--- verilog/fwrisc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module fwrisc_regfile (
	input logic clock,
	input logic reset,
	fwrisc_rf_if.rf rf,
	input logic [fwrisc_csr_pkg::reg_idx_w-1:0] dbg_addr,
	output logic [fwrisc_csr_pkg::xlen-1:0] dbg_data
);
	import fwrisc_csr_pkg::*;

	localparam int n_entries = 2 ** reg_idx_w;

	// entries 0..31 are x0..x31, entries 32..63 hold the CSRs
	logic [xlen-1:0] regs [0:n_entries-1];

	// all reads are combinational
	assign rf.rs1_data = regs[rf.rs1_addr];
	assign rf.csr_data = regs[rf.csr_addr];
	assign dbg_data = regs[dbg_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < n_entries; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// x0 stays zero whatever is written to it
			if (rf.gpr_we && (rf.gpr_waddr != '0)) begin
				regs[rf.gpr_waddr] <= rf.gpr_wdata;
			end
			if (rf.csr_we) begin
				regs[rf.csr_waddr] <= rf.csr_wdata; // never collides with the GPR port
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/fwrisc_csr_exec.sv
`timescale 1ns/1ps
`default_nettype none

module fwrisc_csr_exec (
	input logic clock,
	input logic reset,
	fwrisc_decode_if.exec dec,
	fwrisc_rf_if.exec rf,
	output logic complete,
	output logic illegal,
	output logic [fwrisc_csr_pkg::xlen-1:0] result
);
	import fwrisc_csr_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] csr_old;
	logic [xlen-1:0] csr_new;
	logic do_write;
	logic complete_r;

	// register source and CSR are read in the cycle decode_valid is high
	assign rf.rs1_addr = {1'b0, dec.rs1};
	assign rf.csr_addr = dec.csr;
	assign csr_old = rf.csr_data;

	// the immediate forms zero-extend the 5-bit zimm
	assign op_a = dec.use_zimm ? {{(xlen-5){1'b0}}, dec.zimm} : rf.rs1_data;

	always_comb begin
		case (dec.op)
			OP_OPA: csr_new = op_a;
			OP_OR: csr_new = csr_old | op_a;
			OP_CLR: csr_new = csr_old & ~op_a;
			default: csr_new = op_a;
		endcase
	end

	// an illegal operation writes nothing but still completes
	assign do_write = dec.decode_valid && (dec.op_type == OP_TYPE_CSR);

	// rd receives the old CSR value, the CSR the new one, in the same cycle
	assign rf.gpr_we = do_write;
	assign rf.gpr_waddr = dec.rd;
	assign rf.gpr_wdata = csr_old;
	assign rf.csr_we = do_write;
	assign rf.csr_waddr = dec.csr;
	assign rf.csr_wdata = csr_new;

	// one pulse serves both the decoder handshake and the top-level strobe
	assign dec.instr_complete = complete_r;
	assign complete = complete_r;

	always_ff @(posedge clock) begin
		if (reset) begin
			complete_r <= 1'b0;
			illegal <= 1'b0;
		end else begin
			complete_r <= dec.decode_valid; // decode_valid is low while complete_r is high
			illegal <= dec.decode_valid && (dec.op_type == OP_TYPE_ILLEGAL);
		end
	end

	always_ff @(posedge clock) begin
		if (dec.decode_valid) begin
			result <= do_write ? csr_old : '0; // zero when nothing was written
		end
	end

endmodule

`default_nettype wire

//--- verilog/fwrisc_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module fwrisc_csr_top (
	input logic clock,
	input logic reset,
	input logic instr_valid,
	input logic [fwrisc_csr_pkg::xlen-1:0] instr,
	input logic [fwrisc_csr_pkg::reg_idx_w-1:0] dbg_addr,
	output logic complete,
	output logic illegal,
	output logic [fwrisc_csr_pkg::xlen-1:0] result,
	output logic [fwrisc_csr_pkg::xlen-1:0] dbg_data
);

	fwrisc_decode_if dec_if ();
	fwrisc_rf_if rf_if ();

	// holds one decoded operation until the execute block completes it
	fwrisc_csr_decode i_decode (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.dec(dec_if.decode)
	);

	fwrisc_csr_exec i_exec (
		.clock(clock),
		.reset(reset),
		.dec(dec_if.exec),
		.rf(rf_if.exec),
		.complete(complete),
		.illegal(illegal),
		.result(result)
	);

	// shared GPR and CSR storage with a debug read port
	fwrisc_regfile i_regfile (
		.clock(clock),
		.reset(reset),
		.rf(rf_if.rf),
		.dbg_addr(dbg_addr),
		.dbg_data(dbg_data)
	);

endmodule

`default_nettype wire

//--- tb/fwrisc_csr_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fwrisc_csr_chk (
	input logic clock,
	input logic reset,
	input logic instr_valid,
	input logic complete,
	input logic decode_valid,
	input logic instr_complete
);

	logic accepted;

	// a strobe is taken only while no operation is in flight
	assign accepted = instr_valid && !decode_valid && !instr_complete;

	a_complete_latency: assert property (
		@(posedge clock) disable iff (reset)
		accepted |-> ##2 complete
	) else $error("complete did not follow an accepted strobe by two cycles");

	a_complete_single: assert property (
		@(posedge clock) disable iff (reset)
		complete |=> !complete
	) else $error("complete stayed high for two consecutive cycles");

	// completion answers a valid operation, and valid is gated off in that cycle
	a_valid_gated: assert property (
		@(posedge clock) disable iff (reset)
		instr_complete |-> !decode_valid && $past(decode_valid)
	) else $error("instr_complete without a preceding decode_valid, or with decode_valid high");

endmodule

bind fwrisc_csr_top fwrisc_csr_chk i_chk (
	.clock(clock),
	.reset(reset),
	.instr_valid(instr_valid),
	.complete(complete),
	.decode_valid(dec_if.decode_valid),
	.instr_complete(dec_if.instr_complete)
);

`default_nettype wire

//--- tb/fwrisc_csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fwrisc_csr_tb;

	localparam int n_fixed = 12;
	localparam int n_random = 20;
	localparam int n_tests = n_fixed + n_random;
	localparam int watchdog_cycles = (n_tests + 10) * 4;
	localparam logic [6:0] system_opcode = 7'b1110011;

	logic clock;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic [5:0] dbg_addr;
	logic complete;
	logic illegal;
	logic [31:0] result;
	logic [31:0] dbg_data;

	// stimulus table with the expected illegal flag of each word
	string test_name [0:n_tests-1];
	logic [31:0] test_word [0:n_tests-1];
	logic test_illegal [0:n_tests-1];
	logic test_b2b [0:n_tests-1]; // a second strobe follows one cycle later
	logic [31:0] test_drop_word [0:n_tests-1];

	logic [31:0] model [0:63]; // x0..x31 then the 32 CSR entries
	int n_checks;
	int n_errors;

	fwrisc_csr_top i_dut (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.dbg_addr(dbg_addr),
		.complete(complete),
		.illegal(illegal),
		.result(result),
		.dbg_data(dbg_data)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] encode_system(input logic [11:0] csr, input logic [4:0] src,
			input logic [2:0] funct3, input logic [4:0] rd);
		return {csr, src, funct3, rd, system_opcode};
	endfunction

	function automatic logic [5:0] rd_index(input logic [31:0] word);
		return {1'b0, word[11:7]};
	endfunction

	// only the low 5 bits of the CSR address select an entry
	function automatic logic [5:0] csr_index(input logic [31:0] word);
		return {1'b1, word[24:20]};
	endfunction

	task automatic check_value(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	task automatic set_test(input int idx, input string name, input logic [31:0] word,
			input logic ill, input logic b2b, input logic [31:0] drop_word);
		test_name[idx] = name;
		test_word[idx] = word;
		test_illegal[idx] = ill;
		test_b2b[idx] = b2b;
		test_drop_word[idx] = drop_word;
	endtask

	task automatic build_fixed_tests();
		set_test(0, "csrrwi_first", encode_system(12'h301, 5'd17, 3'b101, 5'd1), 1'b0, 1'b0, '0);
		set_test(1, "csrrwi_second", encode_system(12'h301, 5'd9, 3'b101, 5'd2), 1'b0, 1'b0, '0);
		set_test(2, "csrrw_from_x2", encode_system(12'h342, 5'd2, 3'b001, 5'd3), 1'b0, 1'b0, '0);
		set_test(3, "csrrw_swap", encode_system(12'h301, 5'd2, 3'b001, 5'd4), 1'b0, 1'b0, '0);
		set_test(4, "csrrs_reg", encode_system(12'h342, 5'd4, 3'b010, 5'd5), 1'b0, 1'b0, '0);
		set_test(5, "csrrc_reg", encode_system(12'h342, 5'd2, 3'b011, 5'd6), 1'b0, 1'b0, '0);
		// the follow-up strobe targets the same CSR, so a wrong accept shows up there
		set_test(6, "csrrsi_then_drop", encode_system(12'h301, 5'd6, 3'b110, 5'd7), 1'b0, 1'b1,
			encode_system(12'h301, 5'd30, 3'b101, 5'd9));
		set_test(7, "csrrci", encode_system(12'h301, 5'd3, 3'b111, 5'd8), 1'b0, 1'b0, '0);
		set_test(8, "rd_is_x0", encode_system(12'h305, 5'd31, 3'b101, 5'd0), 1'b0, 1'b0, '0);
		set_test(9, "not_system", 32'h00a50513, 1'b1, 1'b0, '0); // addi x10, x10, 10
		set_test(10, "funct3_000", encode_system(12'h301, 5'd1, 3'b000, 5'd9), 1'b1, 1'b0, '0);
		set_test(11, "funct3_100", encode_system(12'h342, 5'd4, 3'b100, 5'd10), 1'b1, 1'b0, '0);
	endtask

	task automatic build_random_tests();
		logic [31:0] r;
		for (int i = n_fixed; i < n_tests; i++) begin
			r = $urandom;
			// csr, source, rd and funct3 come from disjoint bits of one draw
			set_test(i, $sformatf("random_%0d", i - n_fixed),
				encode_system(r[31:20], r[19:15], r[2:0], r[11:7]),
				r[1:0] == 2'b00, 1'b0, '0);
		end
	endtask

	// applies one legal CSR instruction to the model and returns the old CSR value
	task automatic update_model(input logic [31:0] word, output logic [31:0] old_value);
		logic [2:0] funct3;
		logic [31:0] opa;
		logic [31:0] new_value;
		funct3 = word[14:12];
		old_value = model[csr_index(word)];
		if (funct3[2]) begin
			opa = {27'd0, word[19:15]}; // zimm is zero-extended
		end else begin
			opa = model[{1'b0, word[19:15]}];
		end
		case (funct3[1:0])
			2'b01: new_value = opa;
			2'b10: new_value = old_value | opa;
			default: new_value = old_value & ~opa;
		endcase
		if (rd_index(word) != 6'd0) begin
			model[rd_index(word)] = old_value;
		end
		model[csr_index(word)] = new_value;
	endtask

	task automatic check_reset_state();
		for (int a = 0; a < 64; a += 4) begin
			dbg_addr = a[5:0];
			@(negedge clock);
			check_value("after_reset", $sformatf("entry %0d", a), 32'd0, dbg_data);
			check_value("after_reset", "complete", 32'd0, {31'd0, complete});
			check_value("after_reset", "illegal", 32'd0, {31'd0, illegal});
		end
	endtask

	// entered on a falling edge, the strobe goes out in cycle T
	task automatic run_test(input int idx);
		logic [31:0] word;
		logic [31:0] old_value;
		logic [5:0] rd_idx;
		logic [5:0] csr_idx;
		word = test_word[idx];
		rd_idx = rd_index(word);
		csr_idx = csr_index(word);
		instr = word;
		instr_valid = 1'b1;
		@(negedge clock);
		if (test_b2b[idx]) begin
			instr = test_drop_word[idx]; // lands while the first one is in flight
		end else begin
			instr_valid = 1'b0;
		end
		check_value(test_name[idx], "complete in T+1", 32'd0, {31'd0, complete});
		@(negedge clock);
		instr_valid = 1'b0;
		check_value(test_name[idx], "complete in T+2", 32'd1, {31'd0, complete});
		check_value(test_name[idx], "illegal", {31'd0, test_illegal[idx]}, {31'd0, illegal});
		if (!test_illegal[idx]) begin
			update_model(word, old_value);
			check_value(test_name[idx], "result", old_value, result);
		end
		dbg_addr = rd_idx;
		@(negedge clock);
		check_value(test_name[idx], "complete in T+3", 32'd0, {31'd0, complete});
		check_value(test_name[idx], "rd entry", model[rd_idx], dbg_data);
		dbg_addr = csr_idx;
		@(negedge clock);
		check_value(test_name[idx], "csr entry", model[csr_idx], dbg_data);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		dbg_addr = '0;
		n_checks = 0;
		n_errors = 0;
		void'($urandom(37262));
		for (int i = 0; i < 64; i++) begin
			model[i] = '0;
		end
		build_fixed_tests();
		build_random_tests();
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_reset_state();
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end
		$display("checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// bounds the run at four cycles per table entry plus some slack
	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles before all tests finished", watchdog_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
verilog/fwrisc_csr_pkg.sv
verilog/fwrisc_ifs.sv
verilog/fwrisc_csr_decode.sv
verilog/fwrisc_regfile.sv
verilog/fwrisc_csr_exec.sv
verilog/fwrisc_csr_top.sv
tb/fwrisc_csr_chk.sv
tb/fwrisc_csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := fwrisc_csr_tb
FILELIST := tb.f
OBJ_DIR := obj_dir
COMMON_FLAGS := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only
SIM_FLAGS := --binary --Mdir $(OBJ_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
